// File: logic/rx_decode_pkg.sv
`default_nettype none

package rx_decode_pkg;

   //////////////////////////////
   // frame format
   //////////////////////////////

   // bytes per mac address
   localparam int MAC_LEN = 6;

   // dest address an accepted frame must carry
   localparam logic [8*MAC_LEN-1:0] STATION_ADDR = 48'h5a0102030405;

   // dest + src + type, all ahead of the size field
   localparam int HDR_LEN = 14;

   // size field, msb first, counts seq + payload
   localparam int SIZE_LEN = 2;

   // sequence field, lsb first
   localparam int SEQ_LEN = 2;

   // bytes per output word
   localparam int WORD_BYTES = 4;

   //////////////////////////////
   // beat types
   //////////////////////////////

   // input byte with its frame last flag
   typedef struct packed {
      logic [7:0] data;
      logic       last;
   } byte_beat_t;

   // packed output word, tagged with the frame sequence number
   typedef struct packed {
      logic [8*WORD_BYTES-1:0] data;
      logic [8*SEQ_LEN-1:0]    seq;
      logic                    last;
   } word_beat_t;

   // parser states
   typedef enum logic [2:0] {
      st_idle,     // between frames, enable sampled here
      st_hunt,     // decode off, swallow frame
      st_header,   // dest, src, type
      st_size,     // size field
      st_seq,      // sequence field
      st_payload,  // forward payload bytes
      st_drain     // discard up to input last
   } parse_state_t;

endpackage

`default_nettype wire

// File: logic/axis_skid_slice.sv
`timescale 1ns/1ps
`default_nettype none

module axis_skid_slice #(
   parameter type payload_t = logic [7:0]
) (
   input  wire      axi_tclk,
   input  wire      axi_treset,
   // upstream side
   input  wire      in_valid,
   input  payload_t in_payload,
   output logic     in_ready,
   // downstream side
   output logic     out_valid,
   output payload_t out_payload,
   input  wire      out_ready
);

   // second entry, only filled while the output is stalled
   logic     skid_valid;
   payload_t skid_payload;

   logic in_fire;
   logic out_load;

   assign in_fire  = in_valid & in_ready;
   // output register free or emptying this cycle
   assign out_load = ~out_valid | out_ready;

   //////////////////////////////
   // entry control
   //////////////////////////////

   always_ff @(posedge axi_tclk) begin
      if (axi_treset) begin
         out_valid   <= 1'b0;
         out_payload <= '0;
         skid_valid  <= 1'b0;
         in_ready    <= 1'b0;
      end else begin
         if (out_load) begin
            // older beat in skid goes first
            if (skid_valid) begin
               out_valid   <= 1'b1;
               out_payload <= skid_payload;
               skid_valid  <= 1'b0;
            end else begin
               out_valid <= in_fire;
               if (in_fire) begin
                  out_payload <= in_payload;
               end
            end
            in_ready <= 1'b1;
         end else if (in_fire) begin
            // output stuck, park beat in second entry
            skid_valid <= 1'b1;
            in_ready   <= 1'b0;
         end else begin
            in_ready <= ~skid_valid;
         end
      end
   end

   // skid data
   always_ff @(posedge axi_tclk) begin
      if (in_fire & ~out_load) begin
         skid_payload <= in_payload;
      end
   end

endmodule

`default_nettype wire

// File: logic/rx_header_parser.sv
`timescale 1ns/1ps
`default_nettype none

module rx_header_parser (
   input  wire                                  axi_tclk,
   input  wire                                  axi_treset,
   input  wire                                  enable_rx_decode,
   // byte stream from input slice
   input  wire                                  byte_valid,
   input  wire rx_decode_pkg::byte_beat_t       byte_beat,
   output logic                                 byte_ready,
   // payload byte link to packer
   output logic                                 pay_valid,
   output logic [7:0]                           pay_data,
   output logic                                 pay_last,
   input  wire                                  pay_ready,
   // sequence number, stable for the whole frame
   output logic [8*rx_decode_pkg::SEQ_LEN-1:0]  seq
);

   rx_decode_pkg::parse_state_t state;
   rx_decode_pkg::parse_state_t state_n;

   // byte index inside header, size and seq fields
   logic [$clog2(rx_decode_pkg::HDR_LEN)-1:0]  cnt;

   // expected dest address, shifted one byte per dest byte
   logic [8*rx_decode_pkg::MAC_LEN-1:0]        addr_sr;
   logic [7:0]                                 addr_top;

   logic [8*rx_decode_pkg::SIZE_LEN-1:0]       size_q;
   logic [8*rx_decode_pkg::SIZE_LEN-1:0]       size_full;
   // payload bytes still to forward
   logic [8*rx_decode_pkg::SIZE_LEN-1:0]       pay_rem;

   logic byte_fire;
   logic addr_miss;

   assign byte_fire = byte_valid & byte_ready;
   assign addr_top  = addr_sr[8*rx_decode_pkg::MAC_LEN-1 -: 8];
   // dest bytes only
   assign addr_miss = (cnt < rx_decode_pkg::MAC_LEN) & (byte_beat.data != addr_top);
   // size with current byte as lsb
   assign size_full = {size_q[8*rx_decode_pkg::SIZE_LEN-9:0], byte_beat.data};

   //////////////////////////////
   // payload link
   //////////////////////////////

   // straight through, no register on the payload path
   assign pay_valid = (state == rx_decode_pkg::st_payload) & byte_valid;
   assign pay_data  = byte_beat.data;
   // early input last also ends the frame
   assign pay_last  = (pay_rem == 1) | byte_beat.last;

   always_comb begin
      case (state)
         // one bubble per frame while enable is looked at
         rx_decode_pkg::st_idle:    byte_ready = 1'b0;
         rx_decode_pkg::st_payload: byte_ready = pay_ready;
         default:                   byte_ready = 1'b1;
      endcase
   end

   //////////////////////////////
   // frame fsm
   //////////////////////////////

   always_comb begin
      state_n = state;
      case (state)
         rx_decode_pkg::st_idle: begin
            if (byte_valid) begin
               state_n = enable_rx_decode ? rx_decode_pkg::st_header : rx_decode_pkg::st_hunt;
            end
         end
         rx_decode_pkg::st_header: begin
            if (byte_fire) begin
               if (byte_beat.last) begin
                  state_n = rx_decode_pkg::st_idle;
               end else if (addr_miss) begin
                  state_n = rx_decode_pkg::st_drain;
               end else if (cnt == rx_decode_pkg::HDR_LEN - 1) begin
                  state_n = rx_decode_pkg::st_size;
               end
            end
         end
         rx_decode_pkg::st_size: begin
            if (byte_fire) begin
               if (byte_beat.last) begin
                  state_n = rx_decode_pkg::st_idle;
               end else if (cnt == rx_decode_pkg::SIZE_LEN - 1) begin
                  state_n = rx_decode_pkg::st_seq;
               end
            end
         end
         rx_decode_pkg::st_seq: begin
            if (byte_fire) begin
               if (byte_beat.last) begin
                  state_n = rx_decode_pkg::st_idle;
               end else if (cnt == rx_decode_pkg::SEQ_LEN - 1) begin
                  // empty payload goes straight to drain
                  state_n = (pay_rem == '0) ? rx_decode_pkg::st_drain : rx_decode_pkg::st_payload;
               end
            end
         end
         rx_decode_pkg::st_payload: begin
            if (byte_fire) begin
               if (byte_beat.last) begin
                  state_n = rx_decode_pkg::st_idle;
               end else if (pay_rem == 1) begin
                  // padding or fcs follows
                  state_n = rx_decode_pkg::st_drain;
               end
            end
         end
         // hunt and drain both run to input last
         rx_decode_pkg::st_hunt,
         rx_decode_pkg::st_drain: begin
            if (byte_fire & byte_beat.last) begin
               state_n = rx_decode_pkg::st_idle;
            end
         end
         default: state_n = rx_decode_pkg::st_idle;
      endcase
   end

   always_ff @(posedge axi_tclk) begin
      if (axi_treset) begin
         state   <= rx_decode_pkg::st_idle;
         cnt     <= '0;
         pay_rem <= '0;
      end else begin
         state <= state_n;
         // field counter restarts on every state change
         if (state_n != state) begin
            cnt <= '0;
         end else if (byte_fire) begin
            cnt <= cnt + 1'b1;
         end
         // load payload length on last size byte
         if ((state == rx_decode_pkg::st_size) & byte_fire &
             (cnt == rx_decode_pkg::SIZE_LEN - 1)) begin
            if (size_full > rx_decode_pkg::SEQ_LEN) begin
               pay_rem <= size_full -
                          (8*rx_decode_pkg::SIZE_LEN)'(rx_decode_pkg::SEQ_LEN);
            end else begin
               pay_rem <= '0;
            end
         end else if ((state == rx_decode_pkg::st_payload) & byte_fire) begin
            pay_rem <= pay_rem - 1'b1;
         end
      end
   end

   //////////////////////////////
   // field capture
   //////////////////////////////

   always_ff @(posedge axi_tclk) begin
      // reload expected address for each frame
      if (state == rx_decode_pkg::st_idle) begin
         addr_sr <= rx_decode_pkg::STATION_ADDR;
      end else if ((state == rx_decode_pkg::st_header) & byte_fire) begin
         addr_sr <= addr_sr << 8;
      end
      // size msb first
      if ((state == rx_decode_pkg::st_size) & byte_fire) begin
         size_q <= size_full;
      end
      // seq lsb first, shifts in from the top
      if ((state == rx_decode_pkg::st_seq) & byte_fire) begin
         seq <= {byte_beat.data, seq[8*rx_decode_pkg::SEQ_LEN-1:8]};
      end
   end

endmodule

`default_nettype wire

// File: logic/rx_word_packer.sv
`timescale 1ns/1ps
`default_nettype none

module rx_word_packer (
   input  wire                                    axi_tclk,
   input  wire                                    axi_treset,
   // payload bytes from parser
   input  wire                                    pay_valid,
   input  wire [7:0]                              pay_data,
   input  wire                                    pay_last,
   input  wire [8*rx_decode_pkg::SEQ_LEN-1:0]     seq,
   output logic                                   pay_ready,
   // word beats to output slice
   output logic                                   word_valid,
   output rx_decode_pkg::word_beat_t              word_beat,
   input  wire                                    word_ready
);

   // next free byte lane
   logic [$clog2(rx_decode_pkg::WORD_BYTES)-1:0]  lane;

   // partly filled word
   logic [8*rx_decode_pkg::WORD_BYTES-1:0]        acc;
   // acc with the current byte dropped into its lane
   logic [8*rx_decode_pkg::WORD_BYTES-1:0]        word_n;

   logic pay_fire;
   logic word_end;

   // one word held, stall while it waits
   assign pay_ready = ~word_valid | word_ready;
   assign pay_fire  = pay_valid & pay_ready;
   // full word or end of frame payload
   assign word_end  = (lane == rx_decode_pkg::WORD_BYTES - 1) | pay_last;

   //////////////////////////////
   // lane insert
   //////////////////////////////

   always_comb begin
      // lane 0 starts a fresh word, upper lanes zero
      if (lane == '0) begin
         word_n = '0;
      end else begin
         word_n = acc;
      end
      word_n[8*lane +: 8] = pay_data;
   end

   //////////////////////////////
   // control
   //////////////////////////////

   always_ff @(posedge axi_tclk) begin
      if (axi_treset) begin
         lane       <= '0;
         word_valid <= 1'b0;
      end else begin
         if (word_valid & word_ready) begin
            word_valid <= 1'b0;
         end
         if (pay_fire) begin
            if (word_end) begin
               // lane counter restarts for the next word or frame
               lane       <= '0;
               word_valid <= 1'b1;
            end else begin
               lane <= lane + 1'b1;
            end
         end
      end
   end

   // word data path
   always_ff @(posedge axi_tclk) begin
      if (pay_fire) begin
         acc <= word_n;
         if (word_end) begin
            word_beat.data <= word_n;
            word_beat.seq  <= seq;
            word_beat.last <= pay_last;
         end
      end
   end

endmodule

`default_nettype wire

// File: logic/rx_frame_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module rx_frame_decoder (
   input  wire                                    axi_tclk,
   input  wire                                    axi_treset,
   input  wire                                    enable_rx_decode,
   // byte stream in
   input  wire [7:0]                              rx_axis_tdata,
   input  wire                                    rx_axis_tvalid,
   input  wire                                    rx_axis_tlast,
   output logic                                   rx_axis_tready,
   // word stream out, tuser is the sequence number
   output logic [8*rx_decode_pkg::WORD_BYTES-1:0] tdata,
   output logic [8*rx_decode_pkg::SEQ_LEN-1:0]    tuser,
   output logic                                   tvalid,
   output logic                                   tlast,
   input  wire                                    tready
);

   // input slice to parser
   rx_decode_pkg::byte_beat_t                     in_beat;
   rx_decode_pkg::byte_beat_t                     byte_beat;
   logic                                          byte_valid;
   logic                                          byte_ready;

   // parser to packer
   logic                                          pay_valid;
   logic [7:0]                                    pay_data;
   logic                                          pay_last;
   logic                                          pay_ready;
   logic [8*rx_decode_pkg::SEQ_LEN-1:0]           seq;

   // packer to output slice
   rx_decode_pkg::word_beat_t                     word_beat;
   rx_decode_pkg::word_beat_t                     out_beat;
   logic                                          word_valid;
   logic                                          word_ready;

   assign in_beat = '{data: rx_axis_tdata, last: rx_axis_tlast};

   //////////////////////////////
   // pipeline
   //////////////////////////////

   axis_skid_slice #(.payload_t(rx_decode_pkg::byte_beat_t)) in_slice (
      .axi_tclk(axi_tclk), .axi_treset(axi_treset),
      .in_valid(rx_axis_tvalid), .in_payload(in_beat), .in_ready(rx_axis_tready),
      .out_valid(byte_valid), .out_payload(byte_beat), .out_ready(byte_ready)
   );

   rx_header_parser parser_i (
      .axi_tclk(axi_tclk), .axi_treset(axi_treset), .enable_rx_decode(enable_rx_decode),
      .byte_valid(byte_valid), .byte_beat(byte_beat), .byte_ready(byte_ready),
      .pay_valid(pay_valid), .pay_data(pay_data), .pay_last(pay_last),
      .pay_ready(pay_ready), .seq(seq)
   );

   rx_word_packer packer_i (
      .axi_tclk(axi_tclk), .axi_treset(axi_treset),
      .pay_valid(pay_valid), .pay_data(pay_data), .pay_last(pay_last), .seq(seq),
      .pay_ready(pay_ready), .word_valid(word_valid), .word_beat(word_beat),
      .word_ready(word_ready)
   );

   axis_skid_slice #(.payload_t(rx_decode_pkg::word_beat_t)) out_slice (
      .axi_tclk(axi_tclk), .axi_treset(axi_treset),
      .in_valid(word_valid), .in_payload(word_beat), .in_ready(word_ready),
      .out_valid(tvalid), .out_payload(out_beat), .out_ready(tready)
   );

   // unpack output word beat
   assign tdata = out_beat.data;
   assign tuser = out_beat.seq;
   assign tlast = out_beat.last;

endmodule

`default_nettype wire

// File: dv/rx_decoder_checker.sv
`timescale 1ns/1ps
`default_nettype none

module rx_decoder_checker (
   input  wire                                   axi_tclk,
   input  wire                                   axi_treset,
   input  wire                                   rx_axis_tready,
   input  wire [8*rx_decode_pkg::WORD_BYTES-1:0] tdata,
   input  wire [8*rx_decode_pkg::SEQ_LEN-1:0]    tuser,
   input  wire                                   tvalid,
   input  wire                                   tlast,
   input  wire                                   tready,
   // parser state and packer word, seen through the bind
   input  wire rx_decode_pkg::parse_state_t      parse_state,
   input  wire                                   word_valid
);

   // assertion failures so far
   int fail_count = 0;

   //////////////////////////////
   // output stream rules
   //////////////////////////////

   // stalled beat holds still
   stable_while_stalled: assert property (
      @(posedge axi_tclk) disable iff (axi_treset)
      tvalid & ~tready |=> tvalid & $stable(tdata) & $stable(tuser) & $stable(tlast))
   else begin
      $error("output beat changed while tready was low");
      fail_count++;
   end

   // both ready and valid cleared by reset
   quiet_in_reset: assert property (
      @(posedge axi_tclk)
      axi_treset |=> ~rx_axis_tready & ~tvalid)
   else begin
      $error("rx_axis_tready or tvalid high during reset");
      fail_count++;
   end

   // idle parser, empty packer and slice, so nothing to send
   no_word_from_nothing: assert property (
      @(posedge axi_tclk) disable iff (axi_treset)
      (parse_state == rx_decode_pkg::st_idle) & ~word_valid & ~tvalid |=> ~tvalid)
   else begin
      $error("output beat appeared with no word in flight");
      fail_count++;
   end

endmodule

bind rx_frame_decoder rx_decoder_checker checker_i (
   .axi_tclk(axi_tclk),
   .axi_treset(axi_treset),
   .rx_axis_tready(rx_axis_tready),
   .tdata(tdata),
   .tuser(tuser),
   .tvalid(tvalid),
   .tlast(tlast),
   .tready(tready),
   .parse_state(parser_i.state),
   .word_valid(word_valid)
);

`default_nettype wire

// File: dv/rx_decoder_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module rx_decoder_monitor (
   input  wire                                   axi_tclk,
   input  wire                                   tvalid,
   input  wire                                   tready,
   input  wire [8*rx_decode_pkg::WORD_BYTES-1:0] tdata,
   input  wire [8*rx_decode_pkg::SEQ_LEN-1:0]    tuser,
   input  wire                                   tlast,
   // expected words not yet seen
   output int                                    pending
);

   // expected words in output order
   rx_decode_pkg::word_beat_t exp_q[$];

   int word_idx;
   int test_errors;
   int pass_count;
   int fail_count;

   initial begin
      pending     = 0;
      word_idx    = 0;
      test_errors = 0;
      pass_count  = 0;
      fail_count  = 0;
   end

   task automatic add_expected(input logic [31:0] data, input logic [15:0] seq,
                               input logic last);
      rx_decode_pkg::word_beat_t w;
      w.data = data;
      w.seq  = seq;
      w.last = last;
      exp_q.push_back(w);
      pending = pending + 1;
   endtask

   //////////////////////////////
   // output compare
   //////////////////////////////

   // sample on the falling edge where beat and tready are settled
   always @(negedge axi_tclk) begin
      rx_decode_pkg::word_beat_t w;
      if (tvalid && tready) begin
         if (exp_q.size() == 0) begin
            $display("ERR @%0t: unexpected word data=%h seq=%h last=%b",
                     $time, tdata, tuser, tlast);
            test_errors++;
         end else begin
            w = exp_q.pop_front();
            pending = pending - 1;
            if (w.data !== tdata || w.seq !== tuser || w.last !== tlast) begin
               $display("ERR @%0t: word %0d expected %h seq %h last %b, seen %h seq %h last %b",
                        $time, word_idx, w.data, w.seq, w.last, tdata, tuser, tlast);
               test_errors++;
            end
            word_idx++;
         end
      end
   end

   // one line per finished test
   task automatic close_test(input logic [8*32-1:0] name);
      if (test_errors == 0) begin
         pass_count++;
         $display("test %0s: pass, %0d words", name, word_idx);
      end else begin
         fail_count++;
         $display("test %0s: FAIL, %0d bad words", name, test_errors);
      end
      word_idx    = 0;
      test_errors = 0;
   endtask

endmodule

`default_nettype wire

// File: dv/rx_decoder_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rx_decoder_tb;

   // wait limits in clock cycles
   localparam int HS_LIMIT    = 1000;
   localparam int DRAIN_LIMIT = 4000;
   localparam int SEED        = 30;
   localparam int STR_W       = 8*32;

   logic                                   axi_tclk;
   logic                                   axi_treset;
   logic                                   enable_rx_decode;
   logic [7:0]                             rx_axis_tdata;
   logic                                   rx_axis_tvalid;
   logic                                   rx_axis_tlast;
   logic                                   rx_axis_tready;
   logic [8*rx_decode_pkg::WORD_BYTES-1:0] tdata;
   logic [8*rx_decode_pkg::SEQ_LEN-1:0]    tuser;
   logic                                   tvalid;
   logic                                   tlast;
   logic                                   tready;

   int               pending;
   logic             drained;
   logic             rand_ready;
   logic             aborted;
   logic [STR_W-1:0] test_name;

   rx_frame_decoder dut_i (
      .axi_tclk(axi_tclk), .axi_treset(axi_treset), .enable_rx_decode(enable_rx_decode),
      .rx_axis_tdata(rx_axis_tdata), .rx_axis_tvalid(rx_axis_tvalid),
      .rx_axis_tlast(rx_axis_tlast), .rx_axis_tready(rx_axis_tready),
      .tdata(tdata), .tuser(tuser), .tvalid(tvalid), .tlast(tlast), .tready(tready)
   );

   rx_decoder_monitor mon_i (
      .axi_tclk(axi_tclk), .tvalid(tvalid), .tready(tready),
      .tdata(tdata), .tuser(tuser), .tlast(tlast), .pending(pending)
   );

   // nothing left in slices, parser or packer, and no word still owed
   assign drained = (pending == 0) & ~tvalid & ~dut_i.word_valid & ~dut_i.byte_valid &
                    (dut_i.parser_i.state == rx_decode_pkg::st_idle);

   //////////////////////////////
   // clock and tready
   //////////////////////////////

   initial begin
      axi_tclk = 1'b0;
      forever #20 axi_tclk = ~axi_tclk;
   end

   // random or steady back-pressure
   initial begin
      tready = 1'b0;
      forever begin
         @(posedge axi_tclk);
         #2;
         tready = rand_ready ? 1'($urandom % 2) : 1'b1;
      end
   end

   //////////////////////////////
   // drivers
   //////////////////////////////

   task automatic send_byte(input logic [7:0] data, input logic last);
      int waited;
      waited         = 0;
      rx_axis_tdata  = data;
      rx_axis_tlast  = last;
      rx_axis_tvalid = 1'b1;
      // ready seen at the falling edge holds through the rising one
      @(negedge axi_tclk);
      while (!rx_axis_tready && waited < HS_LIMIT) begin
         @(negedge axi_tclk);
         waited++;
      end
      if (rx_axis_tready) begin
         @(posedge axi_tclk);
         #2;
      end else begin
         $display("timeout: byte %h of test %0s was never accepted", data, test_name);
         aborted = 1'b1;
      end
      rx_axis_tvalid = 1'b0;
   endtask

   task automatic wait_drained();
      int waited;
      waited = 0;
      @(negedge axi_tclk);
      while (!drained && waited < DRAIN_LIMIT) begin
         @(negedge axi_tclk);
         waited++;
      end
      if (drained) begin
         @(posedge axi_tclk);
         #2;
      end else begin
         $display("timeout: test %0s never drained, %0d expected words missing",
                  test_name, pending);
         aborted = 1'b1;
      end
   endtask

   //////////////////////////////
   // test data and summary
   //////////////////////////////

   initial begin
      int               fd;
      int               code;
      int               en;
      int               n;
      int               mode;
      int               w_last;
      int               fails;
      logic             reading;
      logic [STR_W-1:0] tok;
      logic [8*128-1:0] rest;
      logic [31:0]      w_data;
      logic [15:0]      w_seq;
      logic [7:0]       b;

      axi_treset       = 1'b1;
      enable_rx_decode = 1'b0;
      rx_axis_tdata    = '0;
      rx_axis_tvalid   = 1'b0;
      rx_axis_tlast    = 1'b0;
      rand_ready       = 1'b0;
      aborted          = 1'b0;
      test_name        = "none";
      // seed the generator once
      void'($urandom(SEED));
      repeat (8) @(posedge axi_tclk);
      #2;
      axi_treset = 1'b0;

      fd = $fopen("dv/rx_decoder_testdata.txt", "r");
      if (fd == 0) begin
         $display("could not open dv/rx_decoder_testdata.txt");
         aborted = 1'b1;
      end
      reading = (fd != 0);
      while (reading && !aborted) begin
         code = $fscanf(fd, "%s", tok);
         if (code != 1) begin
            reading = 1'b0;
         end else if (tok == "#") begin
            code = $fgets(rest, fd);
         end else if (tok == "test") begin
            code = $fscanf(fd, "%s %d", test_name, mode);
            rand_ready = (mode != 0);
         end else if (tok == "word") begin
            code = $fscanf(fd, "%h %h %d", w_data, w_seq, w_last);
            mon_i.add_expected(w_data, w_seq, w_last[0]);
         end else if (tok == "frame") begin
            code = $fscanf(fd, "%d %d", en, n);
            // parser picks this up at the frame's first byte
            enable_rx_decode = en[0];
            for (int i = 0; i < n && !aborted; i++) begin
               code = $fscanf(fd, "%h", b);
               send_byte(b, i == n - 1);
            end
         end else if (tok == "end") begin
            wait_drained();
            if (!aborted) begin
               mon_i.close_test(test_name);
            end
         end else begin
            $display("unknown keyword %0s in test data file", tok);
            aborted = 1'b1;
         end
      end
      if (fd != 0) begin
         $fclose(fd);
      end

      fails = mon_i.fail_count + dut_i.checker_i.fail_count;
      $display("summary: %0d tests passed, %0d tests failed, %0d assertion failures",
               mon_i.pass_count, mon_i.fail_count, dut_i.checker_i.fail_count);
      if (fails == 0 && !aborted) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog.f
logic/rx_decode_pkg.sv
logic/axis_skid_slice.sv
logic/rx_header_parser.sv
logic/rx_word_packer.sv
logic/rx_frame_decoder.sv
dv/rx_decoder_checker.sv
dv/rx_decoder_monitor.sv
dv/rx_decoder_tb.sv

// File: dv/rx_decoder_testdata.txt
# test <name> <tready mode, 0 always high, 1 random>
# word <tdata hex> <tuser hex> <tlast>, in output order, then frame <enable> <count> <hex bytes>
test matching_12_byte_payload 0
word a3a2a1a0 1234 0
word a7a6a5a4 1234 0
word abaaa9a8 1234 1
frame 1 30
5a 01 02 03 04 05 00 11 22 33 44 55 08 00 00 0e 34 12
a0 a1 a2 a3 a4 a5 a6 a7 a8 a9 aa ab
end
test foreign_address_dropped 0
word 88776655 0002 1
frame 1 22
5a 01 02 03 04 06 00 11 22 33 44 55 08 00 00 06 01 00
11 22 33 44
frame 1 22
5a 01 02 03 04 05 00 11 22 33 44 55 08 00 00 06 02 00
55 66 77 88
end
test short_final_word 0
word c3c2c1c0 0303 0
word 0000c5c4 0303 1
frame 1 24
5a 01 02 03 04 05 00 11 22 33 44 55 08 00 00 08 03 03
c0 c1 c2 c3 c4 c5
end
test trailing_bytes_dropped 0
word d3d2d1d0 0004 0
word 000000d4 0004 1
frame 1 27
5a 01 02 03 04 05 00 11 22 33 44 55 08 00 00 07 04 00
d0 d1 d2 d3 d4 ee ee ff ff
end
test random_ready_back_to_back 1
word e3e2e1e0 0501 0
word e7e6e5e4 0501 1
word 00f2f1f0 0502 1
word 13121110 0503 0
word 17161514 0503 0
word 00000018 0503 1
frame 1 26
5a 01 02 03 04 05 00 11 22 33 44 55 08 00 00 0a 01 05
e0 e1 e2 e3 e4 e5 e6 e7
frame 1 21
5a 01 02 03 04 05 00 11 22 33 44 55 08 00 00 05 02 05
f0 f1 f2
frame 1 27
5a 01 02 03 04 05 00 11 22 33 44 55 08 00 00 0b 03 05
10 11 12 13 14 15 16 17 18
end
test enable_off_then_on 0
word a3a2a1a0 1234 0
word a7a6a5a4 1234 0
word abaaa9a8 1234 1
frame 0 30
5a 01 02 03 04 05 00 11 22 33 44 55 08 00 00 0e 34 12
a0 a1 a2 a3 a4 a5 a6 a7 a8 a9 aa ab
frame 1 30
5a 01 02 03 04 05 00 11 22 33 44 55 08 00 00 0e 34 12
a0 a1 a2 a3 a4 a5 a6 a7 a8 a9 aa ab
end
